// File: fp_cvt.f
+incdir+include
verilog/fp_cvt_pkg.sv
verilog/fp_round_simplified.sv
verilog/fp_f2i_decode.sv
verilog/fp_f2i_execute.sv
verilog/fp_f2i_result.sv
verilog/fp_cvt_unit.sv
sim/fp_cvt_tb.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := fp_cvt_tb
FILELIST  := fp_cvt.f
OBJ_DIR   := obj_dir
PASS_MSG  := PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: sim/fp_cvt_tb.sv
`timescale 1ns/1ps
`include "fp_cvt_settings.svh"

module fp_cvt_tb import fp_cvt_pkg::*;;

  localparam int N_DIR = 23;
  localparam int N_RANDOM = 2000;
  localparam int N_REQUESTS = N_DIR * 10 + N_RANDOM;
  localparam int WATCHDOG_CYCLES = N_REQUESTS * 10 + 200;

  // Integral, fractional, boundary and special operands
  localparam logic [`FLEN-1:0] DIR_OPS [N_DIR] = '{
    32'h0000_0000, 32'h8000_0000, 32'h3f80_0000, 32'hc0e0_0000, 32'h4e80_0000,
    32'h4020_0000, 32'hc020_0000, 32'h3f40_0000, 32'hbe99_999a, 32'h3fc0_0000,
    32'h3f00_0000, 32'hbecc_cccd, 32'h4060_0000, 32'h4f00_0000, 32'hcf00_0000,
    32'h4f80_0000, 32'h4f7f_ffff, 32'h7f80_0000, 32'hff80_0000, 32'h7fc0_0000,
    32'hffc0_0001, 32'h0000_0001, 32'hd015_02f9
  };

  typedef struct packed {
    id_t              id;
    logic [`XLEN-1:0] rd;
    logic [4:0]       fflags;
    logic [31:0]      cyc;
  } expect_t;

  logic        clk;
  logic        rst;
  logic        advance;
  f2i_issue_t  issue;
  f2i_wb_t     wb;
  logic        adv_last;
  logic [31:0] cyc;
  logic [31:0] lcg_state = 32'h357f_9515;
  id_t         next_id;
  int          n_sent;
  int          n_checked;
  expect_t     exp_q[$];

  fp_cvt_unit u_dut (
    .clk     (clk),
    .rst     (rst),
    .advance (advance),
    .issue   (issue),
    .wb      (wb)
  );

  always #2 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Helpers

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [`FLEN-1:0] random_operand();
    logic [31:0] w;
    w = lcg_next();
    // Half the time pull the exponent near the integer range
    if (w[0]) begin
      w[30:23] = 8'd112 + 8'(lcg_next() % 32'd48);
    end
    return w;
  endfunction

  function automatic real pow2(input int n);
    real p;
    p = 1.0;
    if (n >= 0) begin
      repeat (n) p = p * 2.0;
    end else begin
      repeat (-n) p = p / 2.0;
    end
    return p;
  endfunction

  // Reference conversion in real arithmetic giving {rd, fflags}
  function automatic logic [36:0] expected_result(input logic [31:0] bits, input rm_t rm,
                                                  input logic sgn);
    logic       neg;
    logic [7:0] e;
    real        m;
    real        r;
    longint     t;
    longint     v;
    longint     lo;
    longint     hi;
    logic       up;
    neg = bits[31];
    e = bits[30:23];
    if (e == 8'hff && bits[22:0] != 23'd0) begin
      // NaN behaves as a huge positive value
      neg = 1'b0;
      t = longint'(1) << 40;
      r = 0.0;
    end else if (e >= 8'd159) begin
      // At or above 2^32 every case saturates
      t = longint'(1) << 40;
      r = 0.0;
    end else begin
      m = real'({e != 8'd0, bits[22:0]}) * pow2((e == 8'd0) ? -149 : int'(e) - 150);
      t = longint'($floor(m));
      r = m - real'(t);
    end
    case (rm)
      RNE: up = (r > 0.5) || (r == 0.5 && t[0] == 1'b1);
      RTZ: up = 1'b0;
      RDN: up = neg && (r > 0.0);
      RUP: up = !neg && (r > 0.0);
      default: up = (r >= 0.5);
    endcase
    v = t + longint'(up);
    if (neg) begin
      v = -v;
    end
    lo = sgn ? -(longint'(1) << 31) : longint'(0);
    hi = sgn ? (longint'(1) << 31) - 1 : (longint'(1) << 32) - 1;
    if (v < lo) begin
      return {lo[31:0], 5'b10000};
    end else if (v > hi) begin
      return {hi[31:0], 5'b10000};
    end else begin
      return {v[31:0], 4'b0000, r > 0.0};
    end
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("[FAIL] %0t ns %s expected %h got %h", $time, name, expected, actual);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  // Holds the request until an edge with advance high takes it
  task automatic send_request(input logic [31:0] bits, input rm_t rm, input logic sgn,
                              input logic stall);
    f2i_issue_t  req;
    logic        adv;
    logic [31:0] r;
    req.new_request = 1'b1;
    req.id = next_id;
    req.rs1.bits = bits;
    req.rm = rm;
    req.is_signed = sgn;
    r = lcg_next();
    adv = ~stall | (r[31:30] != 2'b00);
    @(posedge clk);
    issue <= req;
    advance <= adv;
    while (!adv) begin
      r = lcg_next();
      adv = (r[31:30] != 2'b00);
      @(posedge clk);
      advance <= adv;
    end
    next_id = next_id + 3'd1;
  endtask

  ////////////////////////////////////////////////////////////
  // Scoreboard

  always @(posedge clk) begin
    expect_t e;
    cyc <= cyc + 32'd1;
    adv_last <= advance;
    if (!rst && advance && issue.new_request) begin
      {e.rd, e.fflags} = expected_result(issue.rs1.bits, issue.rm, issue.is_signed);
      e.id = issue.id;
      e.cyc = cyc;
      exp_q.push_back(e);
      n_sent = n_sent + 1;
    end
  end

  task automatic check_result();
    expect_t e;
    if (exp_q.size() == 0) begin
      abort_run("wb.done went high with no request outstanding");
    end else begin
      e = exp_q.pop_front();
      assert (wb.id == e.id) else report_mismatch("wb.id", 32'(e.id), 32'(wb.id));
      assert (wb.rd == e.rd) else report_mismatch("wb.rd", e.rd, wb.rd);
      assert (wb.fflags == e.fflags)
        else report_mismatch("wb.fflags", 32'(e.fflags), 32'(wb.fflags));
      // Pipeline fill with advance held high
      if (n_checked < 3) begin
        assert (cyc - e.cyc == 32'd3)
          else report_mismatch("done latency", 32'd3, cyc - e.cyc);
      end
      n_checked = n_checked + 1;
    end
  endtask

  // Sample wb at the falling edge after an advance edge
  always @(negedge clk) begin
    if (!rst && adv_last && wb.done === 1'b1) begin
      check_result();
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    abort_run("Timeout: results did not drain within the cycle budget");
  end

  ////////////////////////////////////////////////////////////
  // Stimulus

  initial begin
    logic [31:0] w;
    clk = 1'b0;
    rst = 1'b1;
    advance = 1'b1;
    // A request held through reset must never reach wb
    issue = '0;
    issue.new_request = 1'b1;
    adv_last = 1'b0;
    cyc = '0;
    next_id = '0;
    n_sent = 0;
    n_checked = 0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    issue.new_request <= 1'b0;
    repeat (3) @(posedge clk);

    // Every directed operand in all modes, signed and unsigned
    for (int i = 0; i < N_DIR; i++) begin
      for (int m = 0; m < 5; m++) begin
        for (int s = 0; s < 2; s++) begin
          send_request(DIR_OPS[i], rm_t'(3'(m)), s[0], 1'b0);
        end
      end
    end

    // Back-to-back random operands under random stalls
    for (int i = 0; i < N_RANDOM; i++) begin
      w = lcg_next();
      send_request(random_operand(), rm_t'(3'(w % 32'd5)), w[16], 1'b1);
    end

    @(posedge clk);
    issue.new_request <= 1'b0;
    advance <= 1'b1;
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (5) @(negedge clk);
    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: verilog/fp_cvt_unit.sv
`timescale 1ns/1ps
`include "fp_cvt_settings.svh"

module fp_cvt_unit import fp_cvt_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       advance,
  input  f2i_issue_t issue,
  output f2i_wb_t    wb
);

  f2i_decoded_t  dec;
  f2i_executed_t exe;

  ////////////////////////////////////////////////////////////
  // Stage 1, unpack and classify

  fp_f2i_decode u_decode (
    .clk     (clk),
    .rst     (rst),
    .advance (advance),
    .issue   (issue),
    .dec     (dec)
  );

  ////////////////////////////////////////////////////////////
  // Stage 2, shift, round, range check

  fp_f2i_execute u_execute (
    .clk     (clk),
    .rst     (rst),
    .advance (advance),
    .dec     (dec),
    .exe     (exe)
  );

  ////////////////////////////////////////////////////////////
  // Stage 3, signed sum and writeback

  fp_f2i_result u_result (
    .clk     (clk),
    .rst     (rst),
    .advance (advance),
    .exe     (exe),
    .wb      (wb)
  );

endmodule

// File: verilog/fp_f2i_result.sv
`timescale 1ns/1ps
`include "fp_cvt_settings.svh"

module fp_f2i_result import fp_cvt_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  logic          advance,
  input  f2i_executed_t exe,
  output f2i_wb_t       wb
);

  logic [`XLEN-1:0] in2;
  logic [`XLEN:0]   sum_ext;
  logic [`XLEN-1:0] sat_value;
  f2i_wb_t          wb_d;

  // Negative input gives -roundup - int through ~int with carry-in
  assign in2     = exe.f2i_int ^ {`XLEN{exe.subtract}};
  assign sum_ext = {exe.in1, 1'b1} + {in2, exe.subtract};

  always_comb begin
    if (exe.ovf_unsigned) begin
      sat_value = 32'hffff_ffff;
    end else if (exe.ovf_signed) begin
      sat_value = 32'h7fff_ffff;
    end else if (exe.udf_signed) begin
      sat_value = 32'h8000_0000;
    end else begin
      // Negative unsigned input
      sat_value = '0;
    end
  end

  always_comb begin
    wb_d        = '0;
    wb_d.done   = exe.done;
    wb_d.id     = exe.id;
    wb_d.rd     = exe.special ? sat_value : sum_ext[`XLEN:1];
    wb_d.fflags = {exe.special, 3'b000, exe.inexact & ~exe.special};
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      wb <= wb_d;
    end
    if (rst) begin
      wb.done <= 1'b0;
    end
  end

endmodule

// File: verilog/fp_f2i_execute.sv
`timescale 1ns/1ps
`include "fp_cvt_settings.svh"

module fp_f2i_execute import fp_cvt_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  logic          advance,
  input  f2i_decoded_t  dec,
  output f2i_executed_t exe
);

  localparam int SHIFT_WIDTH = `XLEN + `FRAC_WIDTH;

  logic [SHIFT_WIDTH-1:0] shift_in;
  logic [SHIFT_WIDTH-1:0] int_dot_frac;
  logic [`XLEN-1:0]       f2i_int;
  logic [`FRAC_WIDTH:0]   f2i_frac;
  logic                   sticky;
  logic [2:0]             grs;
  logic                   roundup;
  logic                   inexact;
  logic [`XLEN-1:0]       in1;

  logic                   int_all_ones;
  logic                   int_max_signed;
  logic                   int_min_signed;
  logic                   ovf_unsigned;
  logic                   ovf_signed;
  logic                   udf_signed;
  logic                   neg_unsigned;
  logic                   special;
  f2i_executed_t          exe_d;

  ////////////////////////////////////////////////////////////
  // Integer / fraction split

  // Significand sits at the bottom, integer bits land above FRAC_WIDTH
  assign shift_in     = {{(`XLEN-1){1'b0}}, dec.frac};
  assign int_dot_frac = shift_in << dec.expo_unbiased;

  always_comb begin
    if (dec.int_less_than_1) begin
      f2i_int  = '0;
      f2i_frac = dec.frac;
    end else begin
      {f2i_int, f2i_frac} = {int_dot_frac, 1'b0};
    end
  end

  ////////////////////////////////////////////////////////////
  // Guard, round, sticky

  assign sticky = |f2i_frac[`FRAC_WIDTH-2:0];

  always_comb begin
    if (dec.int_less_than_1) begin
      if (dec.abs_expo_unbiased == 1) begin
        // Value in [0.5, 1)
        grs = {f2i_frac[`FRAC_WIDTH -: 2], sticky};
      end else if (dec.abs_expo_unbiased == 2) begin
        // Value in [0.25, 0.5), guard weight is empty
        grs = {1'b0, f2i_frac[`FRAC_WIDTH], f2i_frac[`FRAC_WIDTH-1] | sticky};
      end else begin
        // Everything folds into sticky
        grs = {2'b00, (|f2i_frac[`FRAC_WIDTH -: 2]) | sticky};
      end
    end else begin
      grs = {f2i_frac[`FRAC_WIDTH -: 2], sticky};
    end
  end

  assign inexact = |grs;

  fp_round_simplified u_round (
    .sign    (dec.sign),
    .rm      (dec.rm),
    .grs     (grs),
    .lsb     (f2i_int[0]),
    .roundup (roundup)
  );

  // Increment moves away from zero in the sign of the input
  assign in1 = dec.subtract ? -`XLEN'(roundup) : `XLEN'(roundup);

  ////////////////////////////////////////////////////////////
  // Range checks on the truncated magnitude

  assign int_all_ones   = &f2i_int;
  assign int_max_signed = ~f2i_int[`XLEN-1] & (&f2i_int[`XLEN-2:0]);
  assign int_min_signed = f2i_int[`XLEN-1] & ~(|f2i_int[`XLEN-2:0]);

  // Above 2^32-1
  assign ovf_unsigned = ~dec.is_signed & ~dec.sign &
                        ((int_all_ones & roundup) | dec.expo_gt_31);

  // Above 2^31-1
  assign ovf_signed = dec.is_signed & ~dec.sign &
                      ((int_max_signed & roundup) | dec.expo_gt_30);

  // Below -2^31, magnitude of exactly 2^31 is still legal
  assign udf_signed = dec.is_signed & dec.sign &
                      ((f2i_int[`XLEN-1] & (~int_min_signed | roundup)) |
                       dec.expo_gt_31);

  // Negative unsigned is only invalid when it does not round to zero
  assign neg_unsigned = ~dec.is_signed & dec.sign &
                        ((|f2i_int) | roundup | dec.expo_gt_31);

  assign special = ovf_unsigned | ovf_signed | udf_signed | neg_unsigned;

  always_comb begin
    exe_d              = '0;
    exe_d.done         = dec.done;
    exe_d.id           = dec.id;
    exe_d.f2i_int      = f2i_int;
    exe_d.in1          = in1;
    exe_d.subtract     = dec.subtract;
    exe_d.ovf_unsigned = ovf_unsigned;
    exe_d.ovf_signed   = ovf_signed;
    exe_d.udf_signed   = udf_signed;
    exe_d.special      = special;
    exe_d.inexact      = inexact;
  end

  ////////////////////////////////////////////////////////////
  // Stage register

  always_ff @(posedge clk) begin
    if (advance) begin
      exe <= exe_d;
    end
    if (rst) begin
      exe.done <= 1'b0;
    end
  end

endmodule

// File: verilog/fp_f2i_decode.sv
`timescale 1ns/1ps
`include "fp_cvt_settings.svh"

module fp_f2i_decode import fp_cvt_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  logic         advance,
  input  f2i_issue_t   issue,
  output f2i_decoded_t dec
);

  logic                        is_zero;
  logic                        is_nan;
  logic                        sign;
  logic signed [`EXPO_WIDTH:0] expo_unbiased;
  logic [`EXPO_WIDTH-1:0]      abs_expo_unbiased;
  logic                        hidden_bit;
  f2i_decoded_t                dec_d;

  ////////////////////////////////////////////////////////////
  // Classification

  // Zero of either sign
  assign is_zero = ~|issue.rs1.bits[`FLEN-2:0];

  // All-ones exponent with a nonzero fraction
  assign is_nan = (&issue.rs1.bits[`FLEN-2:`FRAC_WIDTH]) &
                  (|issue.rs1.bits[`FRAC_WIDTH-1:0]);

  // NaN saturates positive, -0.0 converts like +0.0
  assign sign = issue.rs1.fields.sign & ~is_nan & ~is_zero;

  ////////////////////////////////////////////////////////////
  // Exponent and significand

  assign expo_unbiased = $signed({1'b0, issue.rs1.fields.expo}) -
                         (`EXPO_WIDTH+1)'(`EXPO_BIAS);

  assign abs_expo_unbiased = expo_unbiased[`EXPO_WIDTH] ?
                             `EXPO_WIDTH'(-expo_unbiased) :
                             `EXPO_WIDTH'(expo_unbiased);

  // Denormals carry no hidden one
  assign hidden_bit = |issue.rs1.fields.expo;

  always_comb begin
    dec_d                   = '0;
    dec_d.done              = issue.new_request;
    dec_d.id                = issue.id;
    dec_d.sign              = sign;
    dec_d.expo_unbiased     = expo_unbiased;
    dec_d.abs_expo_unbiased = abs_expo_unbiased;
    dec_d.frac              = {hidden_bit, issue.rs1.fields.frac};
    dec_d.int_less_than_1   = expo_unbiased[`EXPO_WIDTH];
    dec_d.expo_gt_31        = expo_unbiased > 31;
    dec_d.expo_gt_30        = expo_unbiased > 30;
    dec_d.is_signed         = issue.is_signed;
    dec_d.rm                = issue.rm;
    dec_d.subtract          = sign;
  end

  ////////////////////////////////////////////////////////////
  // Stage register, only done is cleared

  always_ff @(posedge clk) begin
    if (advance) begin
      dec <= dec_d;
    end
    if (rst) begin
      dec.done <= 1'b0;
    end
  end

endmodule

// File: verilog/fp_round_simplified.sv
`timescale 1ns/1ps
`include "fp_cvt_settings.svh"

module fp_round_simplified import fp_cvt_pkg::*; (
  input  logic       sign,
  input  rm_t        rm,
  input  logic [2:0] grs,
  input  logic       lsb,
  output logic       roundup
);

  logic guard;
  logic round_bit;
  logic sticky;
  logic any_dropped;

  assign guard       = grs[2];
  assign round_bit   = grs[1];
  assign sticky      = grs[0];
  assign any_dropped = |grs;

  always_comb begin
    case (rm)
      // Ties go to the even integer
      RNE: roundup = guard & (round_bit | sticky | lsb);
      RTZ: roundup = 1'b0;
      // Toward -inf, so only a negative value moves away from zero
      RDN: roundup = sign & any_dropped;
      RUP: roundup = ~sign & any_dropped;
      // Ties away from zero
      RMM: roundup = guard;
      default: roundup = 1'b0;
    endcase
  end

endmodule

// File: verilog/fp_cvt_pkg.sv
`include "fp_cvt_settings.svh"

package fp_cvt_pkg;

  typedef logic [`ID_WIDTH-1:0] id_t;

  // RISC-V rounding mode encoding
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011,
    RMM = 3'b100
  } rm_t;

  typedef struct packed {
    logic                   sign;
    logic [`EXPO_WIDTH-1:0] expo;
    logic [`FRAC_WIDTH-1:0] frac;
  } fp_fields_t;

  // Same operand word, raw or split into IEEE fields
  typedef union packed {
    logic [`FLEN-1:0] bits;
    fp_fields_t       fields;
  } fp_word_u;

  typedef struct packed {
    logic     new_request;
    id_t      id;
    fp_word_u rs1;
    rm_t      rm;
    logic     is_signed;
  } f2i_issue_t;

  typedef struct packed {
    logic                      done;
    id_t                       id;
    logic                      sign;
    logic signed [`EXPO_WIDTH:0] expo_unbiased;
    logic [`EXPO_WIDTH-1:0]    abs_expo_unbiased;
    logic [`FRAC_WIDTH:0]      frac;
    logic                      int_less_than_1;
    logic                      expo_gt_31;
    logic                      expo_gt_30;
    logic                      is_signed;
    rm_t                       rm;
    logic                      subtract;
  } f2i_decoded_t;

  typedef struct packed {
    logic             done;
    id_t              id;
    logic [`XLEN-1:0] f2i_int;
    logic [`XLEN-1:0] in1;
    logic             subtract;
    logic             ovf_unsigned;
    logic             ovf_signed;
    logic             udf_signed;
    logic             special;
    logic             inexact;
  } f2i_executed_t;

  // fflags order is NV, DZ, OF, UF, NX
  typedef struct packed {
    logic             done;
    id_t              id;
    logic [`XLEN-1:0] rd;
    logic [4:0]       fflags;
  } f2i_wb_t;

endpackage

// File: include/fp_cvt_settings.svh
`ifndef FP_CVT_SETTINGS_SVH
`define FP_CVT_SETTINGS_SVH

// Integer datapath width
`define XLEN 32

// Single-precision operand layout
`define FLEN 32
`define EXPO_WIDTH 8
`define FRAC_WIDTH 23

// IEEE 754 single-precision bias
`define EXPO_BIAS 127

// Tag carried alongside each request
`define ID_WIDTH 3

`endif
